// File: src/resize_defs.svh
`ifndef RESIZE_DEFS_SVH
`define RESIZE_DEFS_SVH

// Datapath widths
`define RESIZE_PIX_W          8     // Bits per pixel
`define RESIZE_COORD_W        16    // Bits per coordinate

// Pixel FIFO sizing
`define RESIZE_FIFO_DEPTH     16    // Items held, output stage included
`define RESIZE_FIFO_LVL_W     5     // Level counts 0 to DEPTH

// APB register map
`define RESIZE_APB_AW         8     // Byte address width
`define RESIZE_REG_CTRL       8'h00 // Bit 0 enable
`define RESIZE_REG_SRC_SIZE   8'h04 // Width low half, height high half
`define RESIZE_REG_STEP       8'h08 // X step low half, y step high half, 8.8 each
`define RESIZE_REG_STATUS     8'h0C // Level 4:0, sticky overflow 8 (W1C)

// Field positions inside the register words
`define RESIZE_CTRL_EN_BIT    0
`define RESIZE_STAT_OVF_BIT   8

// Step of 1.0 in 8.8 format, the value after reset
`define RESIZE_STEP_ONE       16'h0100

`endif

// File: src/resize_pkg.sv
`default_nettype none

`include "resize_defs.svh"

package resize_pkg;

  // One source or destination pixel
  typedef logic [`RESIZE_PIX_W-1:0] pixel_t;

  // Image coordinate, counted from 0 at the top left
  typedef logic [`RESIZE_COORD_W-1:0] coord_t;

  // Source-to-destination ratio, 8 integer and 8 fraction bits
  typedef logic [15:0] step_t;

  // What the mapper hands to the FIFO, 40 bits packed
  typedef struct packed {
    pixel_t data;                       // Kept pixel value
    coord_t x;                          // Destination column
    coord_t y;                          // Destination row
  } fifo_item_t;

endpackage

`default_nettype wire

// File: src/resize_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "resize_defs.svh"

module resize_regs
  import resize_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [`RESIZE_APB_AW-1:0]     paddr,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  logic [`RESIZE_FIFO_LVL_W-1:0] fifo_level,
  input  logic                          fifo_ovf,
  output logic                          enable,
  output coord_t                        src_w,
  output coord_t                        src_h,
  output step_t                         x_step,
  output step_t                         y_step,
  output logic                          ovf_clear
);

  logic        access;                  // APB access phase
  logic        wr_en;                   // Write in access phase
  logic        hit_ctrl;
  logic        hit_size;
  logic        hit_step;
  logic        hit_status;
  logic        mapped;                  // Offset decodes to a register
  logic [31:0] status_word;

  assign access     = psel & penable;
  assign wr_en      = access & pwrite;

  assign hit_ctrl   = (paddr == `RESIZE_REG_CTRL);
  assign hit_size   = (paddr == `RESIZE_REG_SRC_SIZE);
  assign hit_step   = (paddr == `RESIZE_REG_STEP);
  assign hit_status = (paddr == `RESIZE_REG_STATUS);
  assign mapped     = hit_ctrl | hit_size | hit_step | hit_status;

  assign pready     = 1'b1;             // No wait states
  assign pslverr    = access & ~mapped; // Unmapped offset, read or write

  // Write 1 to the overflow bit clears the flag held in the FIFO
  assign ovf_clear  = wr_en & hit_status & pwdata[`RESIZE_STAT_OVF_BIT];

  // Live level and sticky flag, rest reads zero
  assign status_word = {23'd0, fifo_ovf,
                        {(8 - `RESIZE_FIFO_LVL_W){1'b0}}, fifo_level};

  // Configuration, updated on the access edge
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      enable <= 1'b0;                   // Mapper idle after reset
      src_w  <= '0;
      src_h  <= '0;
      x_step <= `RESIZE_STEP_ONE;       // 1:1 until software writes a ratio
      y_step <= `RESIZE_STEP_ONE;
    end
    else if (wr_en)
    begin
      if (hit_ctrl)
        enable <= pwdata[`RESIZE_CTRL_EN_BIT];
      if (hit_size)
      begin
        src_w <= pwdata[15:0];          // Width in low half
        src_h <= pwdata[31:16];         // Height in high half
      end
      if (hit_step)
      begin
        x_step <= pwdata[15:0];
        y_step <= pwdata[31:16];
      end
    end
  end

  // Read mux, combinational in the access phase
  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      case (paddr)
        `RESIZE_REG_CTRL:     prdata = {31'd0, enable};
        `RESIZE_REG_SRC_SIZE: prdata = {src_h, src_w};
        `RESIZE_REG_STEP:     prdata = {y_step, x_step};
        `RESIZE_REG_STATUS:   prdata = status_word;
        default:              prdata = '0;           // pslverr flags it
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/resize_coord_map.sv
`timescale 1ns/1ps
`default_nettype none

module resize_coord_map
  import resize_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   enable,
  input  coord_t src_w,
  input  coord_t src_h,
  input  step_t  x_step,
  input  step_t  y_step,
  input  logic   pix_valid,
  input  pixel_t pix_data,
  input  coord_t pix_x,
  input  coord_t pix_y,
  output logic   keep_valid,
  output pixel_t keep_data,
  output coord_t keep_x,
  output coord_t keep_y,
  output logic   frame_done
);

  localparam int FRAC_W = 8;                        // Fraction bits of the step
  localparam int ACC_W  = $bits(coord_t) + FRAC_W;  // Integer part matches a coordinate

  typedef logic [ACC_W-1:0] acc_t;

  // State carried across pixels
  acc_t   x_acc;                        // Next kept source column, 8.8
  acc_t   y_acc;                        // Next kept source row, 8.8
  coord_t dst_x;                        // Destination x of next kept pixel
  coord_t dst_y;                        // Destination y of next kept row
  coord_t row_y;                        // Destination y of the current row
  logic   row_kept;                     // Current row is a kept row

  // Values seen by the pixel in this cycle
  logic   row_start;                    // x 0, row decisions made here
  logic   frame_start;                  // x 0 and y 0
  acc_t   x_acc_cur;
  acc_t   y_acc_cur;
  coord_t dst_x_cur;
  coord_t dst_y_cur;
  coord_t row_y_cur;
  logic   row_keep_cur;
  acc_t   x_step_ext;
  acc_t   y_step_ext;
  logic   col_hit;                      // Column matches accumulator
  logic   hit;                          // Pixel selected by the decimation grid
  logic   keep;                         // Selected and block enabled
  coord_t last_x;
  coord_t last_y;
  logic   last_pix;

  assign row_start   = (pix_x == '0);
  assign frame_start = row_start && (pix_y == '0);
  assign x_step_ext  = acc_t'(x_step);  // Zero extend to accumulator width
  assign y_step_ext  = acc_t'(y_step);

  // Clear points of the rule applied before the compare
  always_comb
  begin
    x_acc_cur = row_start ? '0 : x_acc;
    dst_x_cur = row_start ? '0 : dst_x;
    y_acc_cur = frame_start ? '0 : y_acc;
    dst_y_cur = frame_start ? '0 : dst_y;
    if (row_start)
    begin
      row_keep_cur = (pix_y == y_acc_cur[ACC_W-1:FRAC_W]);  // Row decided at x 0
      row_y_cur    = dst_y_cur;
    end
    else
    begin
      row_keep_cur = row_kept;          // Hold decision for the rest of the row
      row_y_cur    = row_y;
    end
  end

  assign col_hit = (pix_x == x_acc_cur[ACC_W-1:FRAC_W]);
  assign hit     = pix_valid & row_keep_cur & col_hit;
  assign keep    = hit & enable;        // Disabled block keeps nothing

  // Last source pixel of the frame
  assign last_x   = src_w - coord_t'(1);
  assign last_y   = src_h - coord_t'(1);
  assign last_pix = pix_valid && (pix_x == last_x) && (pix_y == last_y);

  // Accumulators and destination counters
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      x_acc    <= '0;
      y_acc    <= '0;
      dst_x    <= '0;
      dst_y    <= '0;
      row_y    <= '0;
      row_kept <= 1'b0;
    end
    else if (pix_valid)
    begin
      if (row_start)
      begin
        row_kept <= row_keep_cur;
        row_y    <= row_y_cur;
        if (row_keep_cur)
        begin
          y_acc <= y_acc_cur + y_step_ext;  // Advance to next kept row
          dst_y <= dst_y_cur + coord_t'(1);
        end
        else
        begin
          y_acc <= y_acc_cur;           // Commits a frame-start clear
          dst_y <= dst_y_cur;
        end
      end
      if (hit)
      begin
        x_acc <= x_acc_cur + x_step_ext;
        dst_x <= dst_x_cur + coord_t'(1);
      end
      else
      begin
        x_acc <= x_acc_cur;             // Commits a row-start clear
        dst_x <= dst_x_cur;
      end
    end
  end

  // Output strobes, one cycle after the input
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      keep_valid <= 1'b0;
      frame_done <= 1'b0;
    end
    else
    begin
      keep_valid <= keep;
      frame_done <= last_pix;           // Single pulse per frame
    end
  end

  // Kept pixel and its destination coordinate
  always_ff @(posedge clk)
  begin
    if (keep)
    begin
      keep_data <= pix_data;
      keep_x    <= dst_x_cur;
      keep_y    <= row_y_cur;
    end
  end

endmodule

`default_nettype wire

// File: src/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "resize_defs.svh"

module pixel_fifo
  import resize_pkg::*;
#(
  parameter int DEPTH = `RESIZE_FIFO_DEPTH  // Power of two
)
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wr_valid,
  input  fifo_item_t                    wr_item,
  input  logic                          rd_ready,
  input  logic                          ovf_clear,
  output logic                          rd_valid,
  output fifo_item_t                    rd_item,
  output logic [`RESIZE_FIFO_LVL_W-1:0] level,
  output logic                          ovf
);

  localparam int AW    = $clog2(DEPTH);
  localparam int LVL_W = `RESIZE_FIFO_LVL_W;

  typedef logic [LVL_W-1:0] lvl_t;

  fifo_item_t mem [DEPTH];              // Ring buffer behind the output stage
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  lvl_t          mem_cnt;               // Items in the ring only

  logic full;
  logic pop;                            // Sink takes the output item
  logic out_free;                       // Output stage can load this edge
  logic mem_empty;
  logic wr_ok;                          // Write accepted
  logic bypass;                         // Write goes straight to output stage
  logic mem_wr;
  logic mem_rd;

  // Level counts the output stage too
  assign level     = mem_cnt + lvl_t'(rd_valid);
  assign full      = (level == lvl_t'(DEPTH));

  assign pop       = rd_valid & rd_ready;
  assign out_free  = ~rd_valid | pop;
  assign mem_empty = (mem_cnt == '0);
  assign wr_ok     = wr_valid & ~full;  // Full FIFO drops the item
  assign bypass    = wr_ok & out_free & mem_empty;
  assign mem_wr    = wr_ok & ~bypass;
  assign mem_rd    = out_free & ~mem_empty;

  // Pointers, count, output valid and sticky overflow
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      mem_cnt  <= '0;
      rd_valid <= 1'b0;
      ovf      <= 1'b0;
    end
    else
    begin
      if (mem_wr)
        wr_ptr <= wr_ptr + 1'b1;        // Wraps at DEPTH
      if (mem_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (mem_wr && !mem_rd)
        mem_cnt <= mem_cnt + lvl_t'(1);
      else if (mem_rd && !mem_wr)
        mem_cnt <= mem_cnt - lvl_t'(1);
      if (out_free)
        rd_valid <= mem_rd | bypass;    // Held while the sink stalls
      if (wr_valid && full)
        ovf <= 1'b1;                    // Set wins over a clear in the same cycle
      else if (ovf_clear)
        ovf <= 1'b0;
    end
  end

  // Storage and output stage payload
  always_ff @(posedge clk)
  begin
    if (mem_wr)
      mem[wr_ptr] <= wr_item;
    if (mem_rd)
      rd_item <= mem[rd_ptr];           // Oldest item first
    else if (bypass)
      rd_item <= wr_item;               // Empty FIFO, one cycle latency
  end

endmodule

`default_nettype wire

// File: src/resize_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "resize_defs.svh"

module resize_top
  import resize_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  // APB slave
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`RESIZE_APB_AW-1:0] paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  // Pixel input, cannot stall
  input  logic                      pix_valid,
  input  pixel_t                    pix_data,
  input  coord_t                    pix_x,
  input  coord_t                    pix_y,
  // Pixel output, ready/valid
  output logic                      out_valid,
  input  logic                      out_ready,
  output pixel_t                    out_data,
  output coord_t                    out_x,
  output coord_t                    out_y,
  output logic                      frame_done
);

  logic   enable;
  coord_t src_w;
  coord_t src_h;
  step_t  x_step;
  step_t  y_step;
  logic   ovf_clear;                    // Write-1 pulse from status register
  logic   fifo_ovf;
  logic [`RESIZE_FIFO_LVL_W-1:0] fifo_level;

  logic       keep_valid;
  pixel_t     keep_data;
  coord_t     keep_x;
  coord_t     keep_y;
  fifo_item_t keep_item;                // Mapper output packed for the FIFO
  fifo_item_t out_item;

  resize_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .fifo_level (fifo_level),
    .fifo_ovf   (fifo_ovf),
    .enable     (enable),
    .src_w      (src_w),
    .src_h      (src_h),
    .x_step     (x_step),
    .y_step     (y_step),
    .ovf_clear  (ovf_clear)
  );

  resize_coord_map u_map (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (enable),
    .src_w      (src_w),
    .src_h      (src_h),
    .x_step     (x_step),
    .y_step     (y_step),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .keep_valid (keep_valid),
    .keep_data  (keep_data),
    .keep_x     (keep_x),
    .keep_y     (keep_y),
    .frame_done (frame_done)
  );

  assign keep_item = '{data: keep_data, x: keep_x, y: keep_y};

  pixel_fifo #(
    .DEPTH (`RESIZE_FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_valid  (keep_valid),
    .wr_item   (keep_item),
    .rd_ready  (out_ready),
    .ovf_clear (ovf_clear),
    .rd_valid  (out_valid),
    .rd_item   (out_item),
    .level     (fifo_level),
    .ovf       (fifo_ovf)
  );

  // Unpack the output stage onto the sink ports
  assign out_data = out_item.data;
  assign out_x    = out_item.x;
  assign out_y    = out_item.y;

endmodule

`default_nettype wire

// File: tests/resize_checker.sv
`timescale 1ns/1ps
`default_nettype none

module resize_checker
  import resize_pkg::*;
(
  input logic   clk,
  input logic   rst_n,
  input logic   pready,
  input logic   out_valid,
  input logic   out_ready,
  input pixel_t out_data,
  input coord_t out_x,
  input coord_t out_y,
  input logic   frame_done
);

  int fail_cnt = 0;                     // Read by the testbench at the end of the run

  // Outputs quiet during reset and in the first cycle after it
  reset_quiet: assert property (@(posedge clk) !rst_n |=> (!out_valid && !frame_done))
    else
    begin
      fail_cnt++;
      $error("out_valid or frame_done high after a reset edge");
    end

  // Stalled item holds still until the sink takes it
  stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=>
      (out_valid && $stable(out_data) && $stable(out_x) && $stable(out_y)))
    else
    begin
      fail_cnt++;
      $error("Output item changed while stalled");
    end

  // No APB wait states
  no_wait: assert property (@(posedge clk) pready)
    else
    begin
      fail_cnt++;
      $error("pready low");
    end

endmodule

`default_nettype wire

// File: tests/resize_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "resize_defs.svh"

module resize_tb
  import resize_pkg::*;
();

  localparam int CLK_PERIOD     = 20;
  localparam int FRAME_PIX      = 10*10 + 8*4 + 10*10 + 8*4;  // All frames sent
  localparam int TIMEOUT_CYCLES = 2*FRAME_PIX + 200;          // Margin for APB and drains

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        pix_valid;
  pixel_t      pix_data;
  coord_t      pix_x;
  coord_t      pix_y;
  logic        out_valid;
  logic        out_ready;
  pixel_t      out_data;
  coord_t      out_x;
  coord_t      out_y;
  logic        frame_done;

  logic [31:0] lfsr;                    // Pixel value source
  pixel_t      frame_mem [0:255];       // Last frame sent in row-major order
  fifo_item_t  exp_q[$];
  fifo_item_t  got_q[$];                // Items taken by the sink
  int          frame_cnt;               // frame_done pulses seen
  int          valid_cycles;
  int          cycle_cnt;
  int          check_cnt;
  int          err_cnt;
  int          err_at_start;
  int          test_cnt;

  resize_top u_resize_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_x      (out_x),
    .out_y      (out_y),
    .frame_done (frame_done)
  );

  bind resize_top resize_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .pready     (pready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_x      (out_x),
    .out_y      (out_y),
    .frame_done (frame_done)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // Sink side monitor samples mid-cycle where outputs are settled
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (out_valid && out_ready)
        got_q.push_back('{data: out_data, x: out_x, y: out_y});
      if (out_valid)
        valid_cycles++;
      if (frame_done)
        frame_cnt++;
    end
  end

  // Watchdog
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run still busy after %0d cycles, a wait on the DUT never ended",
               cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_pixel(output pixel_t px);
    for (int b = 0; b < $bits(pixel_t); b++)
    begin
      px[b] = lfsr[31];                 // One step per bit
      lfsr  = lfsr_step(lfsr);
    end
  endtask

  task automatic check_val(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    check_cnt++;
    if (expected !== actual)
    begin
      err_cnt++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    $display("test %-14s %s", name, (err_cnt == err_at_start) ? "passed" : "failed");
  endtask

  // One APB transfer with a setup phase and then an access phase
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready)
      @(negedge clk);
    rdata = prdata;                     // Valid in access phase
    err   = pslverr;
    @(posedge clk);                     // Access edge
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    check_val("apb write pslverr", 0, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
  endtask

  task automatic configure(input int w, input int h, input logic [15:0] xs,
                           input logic [15:0] ys, input logic en);
    apb_write(`RESIZE_REG_SRC_SIZE, {h[15:0], w[15:0]});
    apb_write(`RESIZE_REG_STEP, {ys, xs});
    apb_write(`RESIZE_REG_CTRL, {31'd0, en});
  endtask

  // Raster order with one pixel per cycle and no gaps
  task automatic send_frame(input int w, input int h);
    pixel_t px;
    for (int y = 0; y < h; y++)
      for (int x = 0; x < w; x++)
      begin
        next_pixel(px);
        frame_mem[y*w + x] = px;
        @(posedge clk);
        #1;
        pix_valid = 1'b1;
        pix_data  = px;
        pix_x     = coord_t'(x);
        pix_y     = coord_t'(y);
      end
    @(posedge clk);
    #1;
    pix_valid = 1'b0;
  endtask

  // Waits for frame_done and then for the output side to run dry or stay stalled
  task automatic wait_frame_end();
    @(negedge clk);
    while (!frame_done)
      @(negedge clk);
    @(negedge clk);
    while (out_valid && out_ready)
      @(negedge clk);
  endtask

  // Nearest-neighbour selection with 8.8 accumulators
  task automatic model_frame(input int w, input int h, input int xs, input int ys);
    int x_acc;
    int y_acc;
    int dx;
    int dy;
    int row_dy;
    bit row_keep;
    exp_q.delete();
    y_acc = 0;
    dy    = 0;
    for (int y = 0; y < h; y++)
    begin
      row_keep = (y == (y_acc >> 8));  // Row decided at x 0
      row_dy   = dy;
      if (row_keep)
      begin
        y_acc += ys;
        dy++;
      end
      x_acc = 0;
      dx    = 0;
      for (int x = 0; x < w; x++)
        if (row_keep && (x == (x_acc >> 8)))
        begin
          exp_q.push_back('{data: frame_mem[y*w + x], x: coord_t'(dx), y: coord_t'(row_dy)});
          x_acc += xs;
          dx++;
        end
    end
  endtask

  task automatic compare_items(input string name);
    check_val({name, " item count"}, exp_q.size(), got_q.size());
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
      check_val($sformatf("%s item %0d", name, i), exp_q[i], got_q[i]);
  endtask

  task automatic test_registers();
    logic [31:0] rd;
    logic        err;
    err_at_start = err_cnt;
    apb_read(`RESIZE_REG_CTRL, rd, err);
    check_val("ctrl after reset", 32'h0, rd);
    apb_read(`RESIZE_REG_STEP, rd, err);
    check_val("step after reset", 32'h0100_0100, rd);
    apb_write(`RESIZE_REG_CTRL, 32'h1);
    apb_read(`RESIZE_REG_CTRL, rd, err);
    check_val("ctrl readback", 32'h1, rd);
    apb_write(`RESIZE_REG_SRC_SIZE, 32'h0123_0456);
    apb_read(`RESIZE_REG_SRC_SIZE, rd, err);
    check_val("src size readback", 32'h0123_0456, rd);
    check_val("src size pslverr", 0, err);
    apb_write(`RESIZE_REG_STEP, 32'h0180_0240);
    apb_read(`RESIZE_REG_STEP, rd, err);
    check_val("step readback", 32'h0180_0240, rd);
    apb_read(8'h10, rd, err);           // First offset past the map
    check_val("unmapped pslverr", 1, err);
    report_test("registers");
  endtask

  task automatic test_half_scale();
    int done0;
    err_at_start = err_cnt;
    configure(10, 10, 16'h0200, 16'h0200, 1'b1);
    got_q.delete();
    exp_q.delete();
    done0 = frame_cnt;
    send_frame(10, 10);
    wait_frame_end();
    for (int j = 0; j < 5; j++)         // Source (2i, 2j) lands on (i, j)
      for (int i = 0; i < 5; i++)
        exp_q.push_back('{data: frame_mem[2*j*10 + 2*i], x: coord_t'(i), y: coord_t'(j)});
    check_val("half scale count", 25, got_q.size());
    compare_items("half scale");
    check_val("half scale frame_done pulses", 1, frame_cnt - done0);
    report_test("half_scale");
  endtask

  task automatic test_fractional();
    err_at_start = err_cnt;
    configure(8, 4, 16'h0180, 16'h0100, 1'b1);
    got_q.delete();
    send_frame(8, 4);
    wait_frame_end();
    model_frame(8, 4, 16'h0180, 16'h0100);
    check_val("fractional count", 24, got_q.size());  // Six columns in each of four rows
    compare_items("fractional");
    report_test("fractional");
  endtask

  task automatic test_disabled();
    int valid0;
    err_at_start = err_cnt;
    configure(10, 10, 16'h0200, 16'h0200, 1'b0);
    got_q.delete();
    valid0 = valid_cycles;
    send_frame(10, 10);
    wait_frame_end();
    check_val("disabled out_valid cycles", 0, valid_cycles - valid0);
    report_test("disabled");
  endtask

  task automatic test_back_pressure();
    logic [31:0] rd;
    logic        err;
    err_at_start = err_cnt;
    configure(8, 4, 16'h0100, 16'h0100, 1'b1);
    got_q.delete();
    out_ready = 1'b0;                   // Sink stalled for the whole frame
    send_frame(8, 4);
    wait_frame_end();
    apb_read(`RESIZE_REG_STATUS, rd, err);
    check_val("stalled level", 16, rd[4:0]);
    check_val("overflow set", 1, rd[8]);
    out_ready = 1'b1;
    @(negedge clk);
    while (out_valid)
      @(negedge clk);
    model_frame(8, 4, 16'h0100, 16'h0100);
    while (exp_q.size() > `RESIZE_FIFO_DEPTH)
      void'(exp_q.pop_back());          // Later items were dropped
    compare_items("back pressure");
    apb_write(`RESIZE_REG_STATUS, 32'h0000_0100);
    apb_read(`RESIZE_REG_STATUS, rd, err);
    check_val("overflow cleared", 0, rd[8]);
    check_val("drained level", 0, rd[4:0]);
    report_test("back_pressure");
  endtask

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    pix_valid    = 1'b0;
    pix_data     = '0;
    pix_x        = '0;
    pix_y        = '0;
    out_ready    = 1'b1;
    lfsr         = 32'h3fe6;
    frame_cnt    = 0;
    valid_cycles = 0;
    cycle_cnt    = 0;
    check_cnt    = 0;
    err_cnt      = 0;
    test_cnt     = 0;
    repeat (2) @(posedge clk);          // Two cycles of reset
    #1;
    rst_n = 1'b1;
    test_registers();
    test_half_scale();
    test_fractional();
    test_disabled();
    test_back_pressure();
    check_val("checker assertion failures", 0, u_resize_top.u_checker.fail_cnt);
    $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/resize_pkg.sv
src/resize_regs.sv
src/resize_coord_map.sv
src/pixel_fifo.sv
src/resize_top.sv
tests/resize_checker.sv
tests/resize_tb.sv

// File: Bender.yml
package:
  name: resize

export_include_dirs:
  - src

sources:
  - src/resize_pkg.sv
  - src/resize_regs.sv
  - src/resize_coord_map.sv
  - src/pixel_fifo.sv
  - src/resize_top.sv
  - target: test
    files:
      - tests/resize_checker.sv
      - tests/resize_tb.sv
